// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = axi4_lite_master_tb
FILELIST  = axi4_lite_master.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== axi4_lite_master.f ====
+incdir+src
src/axi4_lite_pkg.sv
src/axi4_lite_chan_if.sv
src/axi4_lite_strobe_gen.sv
src/axi4_lite_sequencer.sv
src/axi4_lite_channel_regs.sv
src/axi4_lite_master.sv
verification/axi4_lite_slave_model.sv
verification/axi4_lite_master_tb.sv

// ==== src/axi4_lite_cfg.svh ====
`ifndef AXI4_LITE_CFG_SVH
`define AXI4_LITE_CFG_SVH

// bus widths of the 64-bit master

// byte address
`define AXI4_LITE_ADDR_WIDTH 64

`define AXI4_LITE_DATA_WIDTH 64 // one beat
`define AXI4_LITE_STRB_WIDTH 8  // one enable per byte lane

`endif

// ==== src/axi4_lite_chan_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface axi4_lite_chan_if;

	axi4_lite_pkg::master_state_t state;      // current phase
	axi4_lite_pkg::master_state_t state_next; // phase after the coming edge

	// handshake done this cycle
	logic aw_fire;
	logic w_fire;
	logic b_fire;
	logic ar_fire; // address accepted on read side
	logic r_fire;

	modport sequencer
	(
		output state, state_next,
		input  aw_fire, w_fire, b_fire, ar_fire, r_fire
	);

	modport regs
	(
		input  state, state_next,
		output aw_fire, w_fire, b_fire, ar_fire, r_fire
	);

endinterface

`default_nettype wire

// ==== src/axi4_lite_channel_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi4_lite_channel_regs
(
	input  logic                 axi4_lite_clk,
	input  logic                 axi4_lite_rstn,
	input  axi4_lite_pkg::addr_t wr_addr,  // request side, sampled at accept
	input  axi4_lite_pkg::addr_t rd_addr,
	input  axi4_lite_pkg::data_t wr_data,
	input  axi4_lite_pkg::strb_t strb,     // decoded lanes

	// write address
	output axi4_lite_pkg::addr_t m_aw_addr,
	output logic                 m_aw_valid,
	input  logic                 m_aw_ready,

	// write data
	output axi4_lite_pkg::data_t m_w_data,
	output axi4_lite_pkg::strb_t m_w_strb,
	output logic                 m_w_valid,
	input  logic                 m_w_ready,

	// write response
	output logic                 m_b_ready,
	input  logic                 m_b_valid,

	// read address
	output axi4_lite_pkg::addr_t m_ar_addr,
	output logic                 m_ar_valid,
	input  logic                 m_ar_ready,

	// read data
	output logic                 m_r_ready,
	input  logic                 m_r_valid,

	axi4_lite_chan_if.regs       chan
);

	logic wr_start; // write accepted at this edge
	logic rd_start; // read accepted at this edge

	assign wr_start = (chan.state == axi4_lite_pkg::st_idle) &&
		(chan.state_next == axi4_lite_pkg::st_wr_addr);
	assign rd_start = (chan.state == axi4_lite_pkg::st_idle) &&
		(chan.state_next == axi4_lite_pkg::st_rd_addr);

	// request capture, held for the whole transaction
	always_ff @(posedge axi4_lite_clk or negedge axi4_lite_rstn)
	begin
		if (!axi4_lite_rstn)
		begin
			m_aw_addr <= '0;
			m_w_data  <= '0;
			m_w_strb  <= '0;
			m_ar_addr <= '0;
		end
		else
		begin
			if (wr_start)
			begin
				m_aw_addr <= wr_addr;
				m_w_data  <= wr_data; // kept for a retry
				m_w_strb  <= strb;
			end
			if (rd_start)
				m_ar_addr <= rd_addr;
		end
	end

	// one phase flag per channel, straight from the next state
	always_ff @(posedge axi4_lite_clk or negedge axi4_lite_rstn)
	begin
		if (!axi4_lite_rstn)
		begin
			m_aw_valid <= 1'b0;
			m_w_valid  <= 1'b0;
			m_b_ready  <= 1'b0;
			m_ar_valid <= 1'b0;
			m_r_ready  <= 1'b0;
		end
		else
		begin
			m_aw_valid <= (chan.state_next == axi4_lite_pkg::st_wr_addr);
			m_w_valid  <= (chan.state_next == axi4_lite_pkg::st_wr_data);
			m_b_ready  <= (chan.state_next == axi4_lite_pkg::st_wr_resp);
			m_ar_valid <= (chan.state_next == axi4_lite_pkg::st_rd_addr);
			m_r_ready  <= (chan.state_next == axi4_lite_pkg::st_rd_data);
		end
	end

	assign chan.aw_fire = m_aw_valid && m_aw_ready;
	assign chan.w_fire  = m_w_valid && m_w_ready;
	assign chan.b_fire  = m_b_ready && m_b_valid;
	assign chan.ar_fire = m_ar_valid && m_ar_ready;
	assign chan.r_fire  = m_r_ready && m_r_valid;

	// no valid may drop or change payload before its handshake
	a_aw_hold: assert property (@(posedge axi4_lite_clk) disable iff (!axi4_lite_rstn)
		(m_aw_valid && !m_aw_ready) |=> (m_aw_valid && $stable(m_aw_addr)))
		else $error("aw valid/addr changed under back-pressure");

	a_w_hold: assert property (@(posedge axi4_lite_clk) disable iff (!axi4_lite_rstn)
		(m_w_valid && !m_w_ready) |=> (m_w_valid && $stable(m_w_data) && $stable(m_w_strb)))
		else $error("w valid/data/strb changed under back-pressure");

	a_ar_hold: assert property (@(posedge axi4_lite_clk) disable iff (!axi4_lite_rstn)
		(m_ar_valid && !m_ar_ready) |=> (m_ar_valid && $stable(m_ar_addr)))
		else $error("ar valid/addr changed under back-pressure");

endmodule

`default_nettype wire

// ==== src/axi4_lite_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi4_lite_master
(
	input  logic                        axi4_lite_clk,
	input  logic                        axi4_lite_rstn, // async, active low

	// write address
	output axi4_lite_pkg::addr_t        m_aw_addr,
	output logic                        m_aw_valid,
	input  logic                        m_aw_ready,

	// write data
	output axi4_lite_pkg::data_t        m_w_data,
	output axi4_lite_pkg::strb_t        m_w_strb,
	output logic                        m_w_valid,
	input  logic                        m_w_ready,

	// write response
	input  axi4_lite_pkg::resp_t        m_b_resp,
	input  logic                        m_b_valid,
	output logic                        m_b_ready,

	// read address
	output axi4_lite_pkg::addr_t        m_ar_addr,
	output logic                        m_ar_valid,
	input  logic                        m_ar_ready,

	// read data
	input  axi4_lite_pkg::data_t        m_r_data,
	input  axi4_lite_pkg::resp_t        m_r_resp,
	input  logic                        m_r_valid,
	output logic                        m_r_ready,

	// user side
	input  logic                        wr_en,   // one-cycle strobe, idle only
	input  logic                        rd_en,
	input  axi4_lite_pkg::access_size_t byte_en, // write size
	input  axi4_lite_pkg::addr_t        wr_addr,
	input  axi4_lite_pkg::addr_t        rd_addr,
	input  axi4_lite_pkg::data_t        wr_data,
	output axi4_lite_pkg::data_t        rd_data
);

	axi4_lite_pkg::strb_t wr_strb; // decoded, captured by the regs

	axi4_lite_chan_if chan ();

	axi4_lite_strobe_gen u_strobe_gen
	(
		.byte_en (byte_en),
		.wr_addr (wr_addr),
		.strb    (wr_strb)
	);

	axi4_lite_sequencer u_sequencer
	(
		.axi4_lite_clk  (axi4_lite_clk),
		.axi4_lite_rstn (axi4_lite_rstn),
		.wr_en          (wr_en),
		.rd_en          (rd_en),
		.m_b_resp       (m_b_resp),
		.m_r_resp       (m_r_resp),
		.m_r_data       (m_r_data),
		.rd_data        (rd_data),
		.chan           (chan.sequencer)
	);

	axi4_lite_channel_regs u_channel_regs
	(
		.axi4_lite_clk  (axi4_lite_clk),
		.axi4_lite_rstn (axi4_lite_rstn),
		.wr_addr        (wr_addr),
		.rd_addr        (rd_addr),
		.wr_data        (wr_data),
		.strb           (wr_strb),
		.m_aw_addr      (m_aw_addr),
		.m_aw_valid     (m_aw_valid),
		.m_aw_ready     (m_aw_ready),
		.m_w_data       (m_w_data),
		.m_w_strb       (m_w_strb),
		.m_w_valid      (m_w_valid),
		.m_w_ready      (m_w_ready),
		.m_b_ready      (m_b_ready),
		.m_b_valid      (m_b_valid),
		.m_ar_addr      (m_ar_addr),
		.m_ar_valid     (m_ar_valid),
		.m_ar_ready     (m_ar_ready),
		.m_r_ready      (m_r_ready),
		.m_r_valid      (m_r_valid),
		.chan           (chan.regs)
	);

endmodule

`default_nettype wire

// ==== src/axi4_lite_pkg.sv ====
`default_nettype none

`include "axi4_lite_cfg.svh"

package axi4_lite_pkg;

	typedef logic [`AXI4_LITE_ADDR_WIDTH-1:0] addr_t; // byte address
	typedef logic [`AXI4_LITE_DATA_WIDTH-1:0] data_t; // one data beat
	typedef logic [`AXI4_LITE_STRB_WIDTH-1:0] strb_t; // byte lane enables
	typedef logic [1:0]                       resp_t; // bresp / rresp code

	localparam resp_t RESP_OKAY = 2'b00; // normal access done

	// access size from the user side, 2^size bytes
	typedef enum logic [1:0]
	{
		size_byte   = 2'd0, // 8 bit
		size_half   = 2'd1, // 16 bit
		size_word   = 2'd2, // 32 bit
		size_double = 2'd3  // all 64 bits
	} access_size_t;

	// one transaction at a time
	typedef enum logic [2:0]
	{
		st_idle    = 3'd0, // waiting for wr_en / rd_en
		st_wr_addr = 3'd1, // aw valid
		st_wr_data = 3'd2, // w valid
		st_wr_resp = 3'd3, // b ready
		st_rd_addr = 3'd4, // ar valid
		st_rd_data = 3'd5  // r ready
	} master_state_t;

endpackage

`default_nettype wire

// ==== src/axi4_lite_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi4_lite_sequencer
(
	input  logic                 axi4_lite_clk,
	input  logic                 axi4_lite_rstn, // async, active low
	input  logic                 wr_en,          // start a write
	input  logic                 rd_en,          // start a read
	input  axi4_lite_pkg::resp_t m_b_resp,
	input  axi4_lite_pkg::resp_t m_r_resp,
	input  axi4_lite_pkg::data_t m_r_data,
	output axi4_lite_pkg::data_t rd_data,        // last good read beat
	axi4_lite_chan_if.sequencer  chan
);

	axi4_lite_pkg::master_state_t state_q; // registered phase
	axi4_lite_pkg::master_state_t state_d; // phase for the coming edge
	logic b_okay;
	logic r_okay;

	assign b_okay = (m_b_resp == axi4_lite_pkg::RESP_OKAY);
	assign r_okay = (m_r_resp == axi4_lite_pkg::RESP_OKAY);

	always_comb
	begin
		state_d = state_q; // wait for the handshake
		case (state_q)
			axi4_lite_pkg::st_idle:
			begin
				if (wr_en)
					state_d = axi4_lite_pkg::st_wr_addr; // write wins a tie
				else if (rd_en)
					state_d = axi4_lite_pkg::st_rd_addr;
			end
			axi4_lite_pkg::st_wr_addr:
				if (chan.aw_fire)
					state_d = axi4_lite_pkg::st_wr_data;
			axi4_lite_pkg::st_wr_data:
				if (chan.w_fire)
					state_d = axi4_lite_pkg::st_wr_resp;
			axi4_lite_pkg::st_wr_resp:
			begin
				// error response sends the same beat again
				if (chan.b_fire)
					state_d = b_okay ? axi4_lite_pkg::st_idle : axi4_lite_pkg::st_wr_data;
			end
			axi4_lite_pkg::st_rd_addr:
				if (chan.ar_fire)
					state_d = axi4_lite_pkg::st_rd_data;
			axi4_lite_pkg::st_rd_data:
				if (chan.r_fire && r_okay)
					state_d = axi4_lite_pkg::st_idle; // bad beats keep r ready up
			default:
				state_d = axi4_lite_pkg::st_idle;
		endcase
	end

	always_ff @(posedge axi4_lite_clk or negedge axi4_lite_rstn)
	begin
		if (!axi4_lite_rstn)
		begin
			state_q <= axi4_lite_pkg::st_idle;
			rd_data <= '0;
		end
		else
		begin
			state_q <= state_d;
			if ((state_q == axi4_lite_pkg::st_rd_data) && chan.r_fire && r_okay)
				rd_data <= m_r_data; // only okay data lands
		end
	end

	assign chan.state      = state_q;
	assign chan.state_next = state_d;

	a_state_legal: assert property (@(posedge axi4_lite_clk) disable iff (!axi4_lite_rstn)
		state_q inside {axi4_lite_pkg::st_idle, axi4_lite_pkg::st_wr_addr,
			axi4_lite_pkg::st_wr_data, axi4_lite_pkg::st_wr_resp,
			axi4_lite_pkg::st_rd_addr, axi4_lite_pkg::st_rd_data})
		else $error("state left the encoding: %0d", state_q);

	// channel regs keep every valid/ready low while idle
	a_no_fire_idle: assert property (@(posedge axi4_lite_clk) disable iff (!axi4_lite_rstn)
		(state_q == axi4_lite_pkg::st_idle) |->
			!(chan.aw_fire || chan.w_fire || chan.b_fire || chan.ar_fire || chan.r_fire))
		else $error("handshake seen in idle");

endmodule

`default_nettype wire

// ==== src/axi4_lite_strobe_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi4_lite_strobe_gen
(
	input  axi4_lite_pkg::access_size_t byte_en, // access size
	input  axi4_lite_pkg::addr_t        wr_addr, // only low lane bits matter
	output axi4_lite_pkg::strb_t        strb
);

	localparam int LANE_BITS = $clog2($bits(axi4_lite_pkg::strb_t)); // 3 for 8 lanes

	axi4_lite_pkg::strb_t run;       // 2^size ones from lane 0
	logic [LANE_BITS-1:0] lane_base; // first enabled lane

	// lowest set lane, 0 when empty
	function automatic int first_lane(input axi4_lite_pkg::strb_t s);
		int idx;
		idx = 0;
		for (int i = $bits(s) - 1; i >= 0; i--)
			if (s[i])
				idx = i;
		return idx;
	endfunction

	always_comb
	begin
		case (byte_en)
			axi4_lite_pkg::size_byte: run = 'h01;
			axi4_lite_pkg::size_half: run = 'h03;
			axi4_lite_pkg::size_word: run = 'h0f;
			default:                  run = '1; // double word, every lane
		endcase

		// round the address down to the access size
		lane_base = wr_addr[LANE_BITS-1:0] & ~LANE_BITS'((1 << byte_en) - 1);
		strb      = run << lane_base;

		// run holds 2^size lanes and starts on a size boundary
		assert ($countones(strb) == (1 << byte_en))
			else $error("strobe count %0d for size %0d", $countones(strb), byte_en);
		assert (((first_lane(strb) % (1 << byte_en)) == 0) && strb[wr_addr[LANE_BITS-1:0]])
			else $error("strobe run %b misaligned for addr lane %0d", strb,
				wr_addr[LANE_BITS-1:0]);
	end

endmodule

`default_nettype wire

// ==== verification/axi4_lite_master_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi4_lite_master_tb;

	localparam int TIMEOUT_CYCLES = 60 * 40; // transactions x worst cycles each
	localparam axi4_lite_pkg::addr_t BASE = 64'h0000_0000_0000_1000;

	logic axi4_lite_clk;
	logic axi4_lite_rstn;
	axi4_lite_pkg::addr_t m_aw_addr, m_ar_addr, wr_addr, rd_addr;
	axi4_lite_pkg::data_t m_w_data, m_r_data, wr_data, rd_data;
	axi4_lite_pkg::strb_t m_w_strb;
	axi4_lite_pkg::resp_t m_b_resp, m_r_resp;
	axi4_lite_pkg::access_size_t byte_en;
	logic m_aw_valid, m_aw_ready, m_w_valid, m_w_ready, m_b_valid, m_b_ready;
	logic m_ar_valid, m_ar_ready, m_r_valid, m_r_ready;
	logic wr_en, rd_en, b_err_arm, r_err_arm;

	axi4_lite_pkg::addr_t exp_addr, exp_rd_addr; // expected payloads of the current request
	axi4_lite_pkg::data_t exp_data, exp_rd_data; // rd_data must hold the last good read
	axi4_lite_pkg::strb_t exp_strb;
	axi4_lite_pkg::data_t shadow [0:31];
	int aw_count, w_count, b_count, b_ok_count, ar_count, r_ok_count, r_bad_count;
	int cycles;
	logic hold_check; // a bad r beat happened last edge
	logic [63:0] rng;

	axi4_lite_master uut
	(
		.axi4_lite_clk(axi4_lite_clk), .axi4_lite_rstn(axi4_lite_rstn),
		.m_aw_addr(m_aw_addr), .m_aw_valid(m_aw_valid), .m_aw_ready(m_aw_ready),
		.m_w_data(m_w_data), .m_w_strb(m_w_strb), .m_w_valid(m_w_valid),
		.m_w_ready(m_w_ready), .m_b_resp(m_b_resp), .m_b_valid(m_b_valid),
		.m_b_ready(m_b_ready), .m_ar_addr(m_ar_addr), .m_ar_valid(m_ar_valid),
		.m_ar_ready(m_ar_ready), .m_r_data(m_r_data), .m_r_resp(m_r_resp),
		.m_r_valid(m_r_valid), .m_r_ready(m_r_ready), .wr_en(wr_en), .rd_en(rd_en),
		.byte_en(byte_en), .wr_addr(wr_addr), .rd_addr(rd_addr), .wr_data(wr_data),
		.rd_data(rd_data)
	);

	axi4_lite_slave_model u_slave
	(
		.axi4_lite_clk(axi4_lite_clk), .axi4_lite_rstn(axi4_lite_rstn),
		.aw_addr(m_aw_addr), .aw_valid(m_aw_valid), .aw_ready(m_aw_ready),
		.w_data(m_w_data), .w_strb(m_w_strb), .w_valid(m_w_valid), .w_ready(m_w_ready),
		.b_resp(m_b_resp), .b_valid(m_b_valid), .b_ready(m_b_ready),
		.ar_addr(m_ar_addr), .ar_valid(m_ar_valid), .ar_ready(m_ar_ready),
		.r_data(m_r_data), .r_resp(m_r_resp), .r_valid(m_r_valid), .r_ready(m_r_ready),
		.b_err_arm(b_err_arm), .r_err_arm(r_err_arm)
	);

	function automatic logic [63:0] xorshift64(input logic [63:0] s);
		logic [63:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 7);
		x = x ^ (x << 17);
		return x;
	endfunction

	// 2^size lanes from the address rounded down to the size
	function automatic axi4_lite_pkg::strb_t expected_strb(input int sz,
		input axi4_lite_pkg::addr_t a);
		int lanes;
		int base;
		lanes = 1 << sz;
		base  = int'(a[2:0]) & ~(lanes - 1);
		return axi4_lite_pkg::strb_t'(((1 << lanes) - 1) << base);
	endfunction

	task automatic abort_run(input string msg);
		$display("Test failed");
		$fatal(1, "%s", msg);
	endtask

	task automatic check_addr(input string name, input axi4_lite_pkg::addr_t got,
		input axi4_lite_pkg::addr_t exp);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_data(input string name, input axi4_lite_pkg::data_t got,
		input axi4_lite_pkg::data_t exp);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_strb(input string name, input axi4_lite_pkg::strb_t got,
		input axi4_lite_pkg::strb_t exp);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic check_resp_count(input string name, input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name,
				got, exp));
	endtask

	initial
	begin
		axi4_lite_clk = 1'b0;
		forever
			#20 axi4_lite_clk = ~axi4_lite_clk;
	end

	always @(posedge axi4_lite_clk)
	begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
			abort_run("timeout: the master never finished its transactions");
	end

	// compares every beat against the current request
	always @(posedge axi4_lite_clk)
	begin
		if (axi4_lite_rstn)
		begin
			if (hold_check)
			begin
				check_data("rd_data", rd_data, exp_rd_data); // bad beat must not land
				if (!m_r_ready)
					abort_run("m_r_ready dropped after a bad read beat");
				hold_check = 1'b0;
			end
			if (m_aw_valid && m_aw_ready)
			begin
				aw_count++;
				check_addr("m_aw_addr", m_aw_addr, exp_addr);
			end
			if (m_w_valid && m_w_ready)
			begin
				w_count++;
				check_data("m_w_data", m_w_data, exp_data);
				check_strb("m_w_strb", m_w_strb, exp_strb);
			end
			if (m_b_valid && m_b_ready)
			begin
				b_count++;
				if (m_b_resp == axi4_lite_pkg::RESP_OKAY)
					b_ok_count++;
			end
			if (m_ar_valid && m_ar_ready)
			begin
				ar_count++;
				check_addr("m_ar_addr", m_ar_addr, exp_rd_addr);
			end
			if (m_r_valid && m_r_ready)
			begin
				if (m_r_resp == axi4_lite_pkg::RESP_OKAY)
					r_ok_count++;
				else
				begin
					r_bad_count++;
					hold_check = 1'b1;
				end
			end
		end
	end

	task automatic write_request(input axi4_lite_pkg::addr_t a, input int sz,
		input axi4_lite_pkg::data_t d, input bit err, input bit both);
		int aw0, w0, b0, ar0, bok0;
		axi4_lite_pkg::strb_t m;
		m    = expected_strb(sz, a);
		aw0  = aw_count;
		w0   = w_count;
		b0   = b_count;
		ar0  = ar_count;
		bok0 = b_ok_count;
		@(posedge axi4_lite_clk);
		#2;
		exp_addr  = a;
		exp_data  = d;
		exp_strb  = m;
		b_err_arm = err;
		wr_addr   = a;
		wr_data   = d;
		rd_addr   = ~a;
		byte_en   = axi4_lite_pkg::access_size_t'(sz);
		wr_en     = 1'b1;
		rd_en     = both; // write must win the tie
		@(posedge axi4_lite_clk);
		#2;
		wr_addr = ~a; // request already captured
		wr_data = ~d;
		wr_en   = both; // pulse again while busy
		rd_en   = both;
		@(posedge axi4_lite_clk);
		#2;
		wr_en = 1'b0;
		rd_en = 1'b0;
		while (b_ok_count == bok0)
		begin
			@(posedge axi4_lite_clk);
			#2;
		end
		b_err_arm = 1'b0;
		check_resp_count("aw beats", aw_count - aw0, 1);
		check_resp_count("w beats", w_count - w0, 1 + int'(err)); // one resend on slverr
		check_resp_count("b beats", b_count - b0, 1 + int'(err));
		check_resp_count("ar beats", ar_count - ar0, 0);
		for (int i = 0; i < 8; i++)
			if (m[i])
				shadow[a[7:3]][8*i +: 8] = d[8*i +: 8];
	endtask

	task automatic read_request(input axi4_lite_pkg::addr_t a, input bit err);
		int rok0, bad0;
		rok0 = r_ok_count;
		bad0 = r_bad_count;
		@(posedge axi4_lite_clk);
		#2;
		exp_rd_addr = a;
		r_err_arm   = err;
		rd_addr     = a;
		rd_en       = 1'b1;
		@(posedge axi4_lite_clk);
		#2;
		rd_en   = 1'b0;
		rd_addr = ~a;
		while (r_ok_count == rok0)
		begin
			@(posedge axi4_lite_clk);
			#2;
		end
		r_err_arm   = 1'b0;
		exp_rd_data = shadow[a[7:3]];
		check_resp_count("bad r beats", r_bad_count - bad0, int'(err));
		check_data("rd_data", rd_data, exp_rd_data);
	endtask

	initial
	begin
		axi4_lite_pkg::addr_t a;
		axi4_lite_pkg::data_t d;
		rng         = 64'd61917;
		axi4_lite_rstn = 1'b0;
		wr_en       = 1'b0;
		rd_en       = 1'b0;
		byte_en     = axi4_lite_pkg::size_byte;
		wr_addr     = '0;
		rd_addr     = '0;
		wr_data     = '0;
		b_err_arm   = 1'b0;
		r_err_arm   = 1'b0;
		exp_addr    = '0;
		exp_rd_addr = '0;
		exp_data    = '0;
		exp_strb    = '0;
		exp_rd_data = '0;
		hold_check  = 1'b0;
		cycles      = 0;
		aw_count    = 0;
		w_count     = 0;
		b_count     = 0;
		b_ok_count  = 0;
		ar_count    = 0;
		r_ok_count  = 0;
		r_bad_count = 0;
		for (int i = 0; i < 32; i++)
			shadow[i] = '0;
		repeat (4) @(posedge axi4_lite_clk);
		#2;
		axi4_lite_rstn = 1'b1;
		if (m_aw_valid || m_w_valid || m_b_ready || m_ar_valid || m_r_ready)
			abort_run("a valid or ready is high after reset");
		check_data("rd_data", rd_data, '0);

		// every size at every legal offset, each read back
		for (int sz = 0; sz < 4; sz++)
			for (int off = 0; off < 8; off += (1 << sz))
			begin
				rng = xorshift64(rng);
				a   = BASE + 64'({rng[4:0], 3'b000}) + 64'(off);
				rng = xorshift64(rng);
				d   = rng;
				write_request(a, sz, d, 1'b0, 1'b0);
				read_request({a[63:3], 3'b000}, 1'b0);
			end

		// slverr on first b, one resend
		write_request(BASE + 64'h18, 3, 64'h0123_4567_89ab_cdef, 1'b1, 1'b0);
		read_request(BASE + 64'h18, 1'b0);
		write_request(BASE + 64'h22, 1, 64'h0000_0000_beef_0000, 1'b1, 1'b0);
		read_request(BASE + 64'h20, 1'b0);

		// bad r beat ignored
		read_request(BASE + 64'h18, 1'b1);
		read_request(BASE + 64'h20, 1'b1);

		// tie and busy pulses
		write_request(BASE + 64'h40, 2, 64'hcafe_f00d_1357_2468, 1'b0, 1'b1);
		read_request(BASE + 64'h40, 1'b0);

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/axi4_lite_slave_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi4_lite_slave_model
(
	input  logic                 axi4_lite_clk,
	input  logic                 axi4_lite_rstn,
	input  axi4_lite_pkg::addr_t aw_addr,
	input  logic                 aw_valid,
	output logic                 aw_ready,
	input  axi4_lite_pkg::data_t w_data,
	input  axi4_lite_pkg::strb_t w_strb,
	input  logic                 w_valid,
	output logic                 w_ready,
	output axi4_lite_pkg::resp_t b_resp,
	output logic                 b_valid,
	input  logic                 b_ready,
	input  axi4_lite_pkg::addr_t ar_addr,
	input  logic                 ar_valid,
	output logic                 ar_ready,
	output axi4_lite_pkg::data_t r_data,
	output axi4_lite_pkg::resp_t r_resp,
	output logic                 r_valid,
	input  logic                 r_ready,
	input  logic                 b_err_arm, // first b of this write is slverr
	input  logic                 r_err_arm  // one bad r beat before the good one
);

	localparam axi4_lite_pkg::resp_t RESP_SLVERR = 2'b10;

	logic [63:0]          rng;  // one draw per cycle, slices per channel
	axi4_lite_pkg::data_t mem [0:31]; // word index from addr[7:3]
	axi4_lite_pkg::addr_t aw_addr_q;
	axi4_lite_pkg::addr_t ar_addr_q;
	logic [1:0] aw_wait, w_wait, b_wait, ar_wait, r_wait; // 0..3 cycle delays
	logic b_pend, b_err_q, r_pend, r_bad_q;

	function automatic logic [63:0] xorshift64(input logic [63:0] s);
		logic [63:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 7);
		x = x ^ (x << 17);
		return x;
	endfunction

	always_ff @(posedge axi4_lite_clk or negedge axi4_lite_rstn)
	begin
		if (!axi4_lite_rstn)
		begin
			rng       <= 64'd61917;
			aw_ready  <= 1'b0;
			w_ready   <= 1'b0;
			b_valid   <= 1'b0;
			b_resp    <= '0;
			ar_ready  <= 1'b0;
			r_valid   <= 1'b0;
			r_resp    <= '0;
			r_data    <= '0;
			aw_addr_q <= '0;
			ar_addr_q <= '0;
			aw_wait   <= '0;
			w_wait    <= '0;
			b_wait    <= '0;
			ar_wait   <= '0;
			r_wait    <= '0;
			b_pend    <= 1'b0;
			b_err_q   <= 1'b0;
			r_pend    <= 1'b0;
			r_bad_q   <= 1'b0;
			for (int i = 0; i < 32; i++)
				mem[i] <= '0;
		end
		else
		begin
			rng <= xorshift64(rng);
			// write address
			if (aw_valid && aw_ready)
			begin
				aw_ready  <= 1'b0;
				aw_addr_q <= aw_addr;
				b_err_q   <= b_err_arm;
				aw_wait   <= rng[1:0];
			end
			else if (aw_valid)
			begin
				if (aw_wait == 0)
					aw_ready <= 1'b1;
				else
					aw_wait <= aw_wait - 1'b1;
			end
			// write data, merged by lane
			if (w_valid && w_ready)
			begin
				w_ready <= 1'b0;
				for (int i = 0; i < 8; i++)
					if (w_strb[i])
						mem[aw_addr_q[7:3]][8*i +: 8] <= w_data[8*i +: 8];
				b_pend <= 1'b1;
				b_wait <= rng[3:2];
				w_wait <= rng[5:4];
			end
			else if (w_valid)
			begin
				if (w_wait == 0)
					w_ready <= 1'b1;
				else
					w_wait <= w_wait - 1'b1;
			end
			// write response
			if (b_valid && b_ready)
			begin
				b_valid <= 1'b0;
				b_err_q <= 1'b0; // error only once per write
			end
			else if (b_pend && !b_valid)
			begin
				if (b_wait == 0)
				begin
					b_valid <= 1'b1;
					b_resp  <= b_err_q ? RESP_SLVERR : axi4_lite_pkg::RESP_OKAY;
					b_pend  <= 1'b0;
				end
				else
					b_wait <= b_wait - 1'b1;
			end
			// read address
			if (ar_valid && ar_ready)
			begin
				ar_ready  <= 1'b0;
				ar_addr_q <= ar_addr;
				r_bad_q   <= r_err_arm;
				r_pend    <= 1'b1;
				r_wait    <= rng[7:6];
				ar_wait   <= rng[9:8];
			end
			else if (ar_valid)
			begin
				if (ar_wait == 0)
					ar_ready <= 1'b1;
				else
					ar_wait <= ar_wait - 1'b1;
			end
			// read data, a bad beat is followed by another
			if (r_valid && r_ready)
			begin
				r_valid <= 1'b0;
				if (r_resp != axi4_lite_pkg::RESP_OKAY)
				begin
					r_pend <= 1'b1;
					r_wait <= rng[11:10];
				end
			end
			else if (r_pend && !r_valid)
			begin
				if (r_wait == 0)
				begin
					r_valid <= 1'b1;
					r_pend  <= 1'b0;
					if (r_bad_q)
					begin
						r_resp  <= RESP_SLVERR;
						r_data  <= ~mem[ar_addr_q[7:3]] ^ 64'h5a5a_0f0f_a5a5_f0f0; // garbage
						r_bad_q <= 1'b0;
					end
					else
					begin
						r_resp <= axi4_lite_pkg::RESP_OKAY;
						r_data <= mem[ar_addr_q[7:3]];
					end
				end
				else
					r_wait <= r_wait - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire
